// ==== common/loader_settings.svh ====
// Loader settings
// Address bases, header length, page sizes and memory slot timing
// for the cartridge image loader

`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// iNES header length in bytes
`define LOADER_HEADER_BYTES 16

// Memory bases, 22-bit byte addresses
`define LOADER_PRG_BASE 22'h000000
`define LOADER_CHR_BASE 22'h200000

// Page sizes as shift amounts
`define LOADER_PRG_PAGE_SHIFT 14 // 16 KB per PRG page
`define LOADER_CHR_PAGE_SHIFT 13 // 8 KB per CHR page

// Clocks between console memory slots
`define LOADER_SLOT_PERIOD 4

`endif

// ==== common/ines_pkg.sv ====
// iNES file format types
// Header and payload bytes, page counts, size codes and the packed
// mapper flag word handed to the console core

package ines_pkg;

	// One header or payload byte
	typedef logic [7:0] ines_byte_t;

	// PRG or CHR page count, header bytes 4 and 5
	typedef logic [7:0] page_count_t;

	// log2 size code, 0 for one page or fewer, 7 above 64 pages
	typedef logic [2:0] size_code_t;

	// Signature bytes 0 to 3, "NES" then 0x1A
	localparam logic [31:0] INES_MAGIC = 32'h4E45_531A;

	// Byte 6 bit positions
	localparam int INES_MIRROR_BIT  = 0;
	localparam int INES_BATTERY_BIT = 1;
	localparam int INES_TRAINER_BIT = 2;
	localparam int INES_FOUR_SCR_BIT = 3;

	// Byte 7 bits 3:2 for a NES 2.0 header
	localparam logic [1:0] INES_NES20_ID = 2'b10;

	////////////////////////////////////////////////////////////////////////////
	// Packed mapper flags, 32 bits
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] zero;
		logic       battery;
		ines_byte_t nes20_mapper; // Byte 8 of a NES 2.0 header
		logic       four_screen;
		logic       chr_ram;      // No CHR ROM in the image
		logic       mirroring;
		size_code_t chr_size;
		size_code_t prg_size;
		ines_byte_t mapper;
	} mapper_flags_t;

endpackage

// ==== common/loader_pkg.sv ====
// Loader machinery types
// Memory addresses, byte counters and the state encodings of the
// header parser and the address sequencer

package loader_pkg;

	// Byte address into cartridge memory
	typedef logic [21:0] mem_addr_t;

	// Bytes still to load in the current region
	typedef logic [21:0] byte_count_t;

	// Header parser
	typedef enum logic [1:0] {
		WAIT_HEADER, // Collecting the 16 header bytes
		STREAM,      // Header good, payload passes through
		REJECTED     // Bad signature or trainer, bytes ignored
	} parse_state_t;

	// Address sequencer
	typedef enum logic [1:0] {
		IDLE,
		LOAD_PRG,
		LOAD_CHR,  // Also drains the last outstanding write
		FINISHED
	} seq_state_t;

endpackage

// ==== design/mem_write_buffer.sv ====
`timescale 1ns/1ns
`include "loader_settings.svh"

// Memory write buffer
// Holds one loader write until the next console memory slot and
// keeps the host waiting while the write is outstanding

module mem_write_buffer (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic                  wr_req,
	input  loader_pkg::mem_addr_t wr_addr,
	input  ines_pkg::ines_byte_t  wr_data,
	output logic                  wr_done,
	output logic                  in_wait,
	output logic                  mem_write,
	output loader_pkg::mem_addr_t mem_addr,
	output ines_pkg::ines_byte_t  mem_data
);
	import ines_pkg::*;
	import loader_pkg::*;

	localparam int SLOT_W = $clog2(`LOADER_SLOT_PERIOD);

	logic [SLOT_W-1:0] slot_cnt;   // Free running, one slot per period
	logic              slot;
	logic              held;
	logic              direct;     // Request lands right on a slot
	mem_addr_t         hold_addr;
	ines_byte_t        hold_data;

	assign slot   = slot_cnt == SLOT_W'(`LOADER_SLOT_PERIOD - 1);
	assign direct = wr_req && slot && !held;

	// High from the cycle after a request through its commit cycle
	assign in_wait = held | mem_write;
	assign wr_done = mem_write;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			slot_cnt  <= '0;
			held      <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			slot_cnt  <= slot ? '0 : slot_cnt + 1'b1;
			mem_write <= (held && slot) || direct;
			if (held && slot)
				held <= 1'b0;
			if (wr_req && !direct)
				held <= 1'b1; // Wait for the next slot
		end
	end

	always_ff @(posedge clk) begin
		if (wr_req && !direct) begin
			hold_addr <= wr_addr;
			hold_data <= wr_data;
		end
		if (held && slot) begin
			mem_addr <= hold_addr;
			mem_data <= hold_data;
		end else if (direct) begin
			mem_addr <= wr_addr;
			mem_data <= wr_data;
		end
	end

endmodule

// ==== game_loader/ines_header_parser.sv ====
`timescale 1ns/1ns
`include "loader_settings.svh"

// iNES header parser
// Collects the header, checks signature and trainer, packs the mapper
// flags and forwards the payload bytes to the address sequencer

module ines_header_parser (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    in_strobe,
	input  ines_pkg::ines_byte_t    in_data,
	input  logic                    invert_mirroring,
	output logic                    load_start,
	output ines_pkg::page_count_t   prg_pages,
	output ines_pkg::page_count_t   chr_pages,
	output logic                    pay_strobe,
	output ines_pkg::ines_byte_t    pay_data,
	output logic                    error,
	output ines_pkg::mapper_flags_t flags
);
	import ines_pkg::*;
	import loader_pkg::*;

	localparam int LAST_IDX = `LOADER_HEADER_BYTES - 1;

	parse_state_t  state;
	logic [$clog2(`LOADER_HEADER_BYTES)-1:0] hdr_idx;
	ines_byte_t    hdr [`LOADER_HEADER_BYTES];
	ines_byte_t    hdr_view [`LOADER_HEADER_BYTES]; // Includes the byte arriving now
	logic          header_end;
	logic          is_nes20;
	logic          is_dirty;
	logic          bad_header;
	mapper_flags_t flags_next;

	// Smallest power of two page count that covers the image
	function automatic size_code_t size_code(input page_count_t pages);
		size_code_t code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (9'd1 << i))
				code = size_code_t'(i);
		end
		return code;
	endfunction

	always_comb begin
		for (int i = 0; i < `LOADER_HEADER_BYTES; i++)
			hdr_view[i] = hdr[i];
		hdr_view[LAST_IDX] = in_data;
	end

	assign header_end = in_strobe && state == WAIT_HEADER && hdr_idx == LAST_IDX;
	assign is_nes20   = hdr_view[7][3:2] == INES_NES20_ID;
	// Junk in bytes 9..15 of an old iNES 1.0 dump
	assign is_dirty   = !is_nes20 && ((|hdr_view[9][7:1]) || (|hdr_view[10])
		|| (|hdr_view[11]) || (|hdr_view[12]) || (|hdr_view[13])
		|| (|hdr_view[14]) || (|hdr_view[15]));
	assign bad_header = {hdr_view[0], hdr_view[1], hdr_view[2], hdr_view[3]} != INES_MAGIC
		|| hdr_view[6][INES_TRAINER_BIT];

	always_comb begin
		flags_next              = '0;
		flags_next.battery      = hdr_view[6][INES_BATTERY_BIT];
		flags_next.nes20_mapper = is_nes20 ? hdr_view[8] : 8'h00;
		flags_next.four_screen  = hdr_view[6][INES_FOUR_SCR_BIT];
		flags_next.chr_ram      = hdr_view[5] == 8'h00;
		flags_next.mirroring    = hdr_view[6][INES_MIRROR_BIT] ^ invert_mirroring;
		flags_next.chr_size     = size_code(hdr_view[5]);
		flags_next.prg_size     = size_code(hdr_view[4]);
		flags_next.mapper       = {is_dirty ? 4'h0 : hdr_view[7][7:4], hdr_view[6][7:4]};
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= WAIT_HEADER;
			hdr_idx    <= '0;
			load_start <= 1'b0;
			pay_strobe <= 1'b0;
			error      <= 1'b0;
		end else begin
			load_start <= header_end; // Zero page counts on a rejected image
			pay_strobe <= in_strobe && state == STREAM;
			if (in_strobe && state == WAIT_HEADER)
				hdr_idx <= hdr_idx + 1'b1;
			if (header_end) begin
				state <= bad_header ? REJECTED : STREAM;
				error <= bad_header;
			end
		end
	end

	// Header bytes and payload
	always_ff @(posedge clk) begin
		if (in_strobe && state == WAIT_HEADER)
			hdr[hdr_idx] <= in_data;
		if (header_end) begin
			prg_pages <= bad_header ? 8'h00 : hdr_view[4];
			chr_pages <= bad_header ? 8'h00 : hdr_view[5];
			flags     <= flags_next;
		end
		if (in_strobe)
			pay_data <= in_data;
	end

endmodule

// ==== game_loader/rom_address_sequencer.sv ====
`timescale 1ns/1ns
`include "loader_settings.svh"

// ROM address sequencer
// Counts the PRG bytes, then the CHR bytes, gives each byte its memory
// address and reports done once the last write has committed

module rom_address_sequencer (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic                  load_start,
	input  ines_pkg::page_count_t prg_pages,
	input  ines_pkg::page_count_t chr_pages,
	input  logic                  pay_strobe,
	input  ines_pkg::ines_byte_t  pay_data,
	input  logic                  wr_done,
	output logic                  wr_req,
	output loader_pkg::mem_addr_t wr_addr,
	output ines_pkg::ines_byte_t  wr_data,
	output logic                  busy,
	output logic                  done
);
	import ines_pkg::*;
	import loader_pkg::*;

	seq_state_t  state;
	byte_count_t bytes_left;
	mem_addr_t   next_addr;
	page_count_t chr_held;     // CHR pages kept for the switch after PRG
	logic [1:0]  pending;      // Issued but not yet committed
	byte_count_t prg_load;
	byte_count_t chr_load_now;
	byte_count_t chr_load_held;
	logic        issue;
	logic        prg_last;
	logic        drained;

	assign prg_load      = byte_count_t'(prg_pages) << `LOADER_PRG_PAGE_SHIFT;
	assign chr_load_now  = byte_count_t'(chr_pages) << `LOADER_CHR_PAGE_SHIFT;
	assign chr_load_held = byte_count_t'(chr_held) << `LOADER_CHR_PAGE_SHIFT;

	// Bytes past the counts fall through here and are dropped
	assign issue    = pay_strobe && bytes_left != '0
		&& (state == LOAD_PRG || state == LOAD_CHR);
	assign prg_last = state == LOAD_PRG && bytes_left == byte_count_t'(1);
	assign drained  = state == LOAD_CHR && bytes_left == '0
		&& (pending == 2'd0 || (pending == 2'd1 && wr_done));

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= IDLE;
			bytes_left <= '0;
			pending    <= 2'd0;
			wr_req     <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
		end else begin
			wr_req  <= issue;
			pending <= pending + {1'b0, issue} - {1'b0, wr_done};
			case (state)
				IDLE: begin
					if (load_start) begin
						if (prg_pages != '0) begin
							state      <= LOAD_PRG;
							bytes_left <= prg_load;
							busy       <= 1'b1;
						end else if (chr_pages != '0) begin
							state      <= LOAD_CHR;
							bytes_left <= chr_load_now;
							busy       <= 1'b1;
						end else begin
							state <= FINISHED; // Nothing to load, or rejected
							done  <= 1'b1;
						end
					end
				end
				LOAD_PRG: begin
					if (issue)
						bytes_left <= prg_last ? chr_load_held : bytes_left - 1'b1;
					if (issue && prg_last)
						state <= LOAD_CHR; // Zero CHR count just drains
				end
				LOAD_CHR: begin
					if (issue) begin
						bytes_left <= bytes_left - 1'b1;
					end else if (drained) begin
						state <= FINISHED;
						busy  <= 1'b0;
						done  <= 1'b1;
					end
				end
				default: ; // FINISHED holds until reset
			endcase
		end
	end

	// Address counter and write payload
	always_ff @(posedge clk) begin
		if (load_start && state == IDLE) begin
			chr_held  <= chr_pages;
			next_addr <= (prg_pages != '0) ? `LOADER_PRG_BASE : `LOADER_CHR_BASE;
		end else if (issue) begin
			wr_addr   <= next_addr;
			wr_data   <= pay_data;
			next_addr <= prg_last ? `LOADER_CHR_BASE : next_addr + 1'b1;
		end
	end

endmodule

// ==== game_loader/game_loader.sv ====
`timescale 1ns/1ns

// Cartridge image loader
// Header parser, address sequencer and write buffer in a pipeline
// between the host download stream and cartridge memory

module game_loader (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    in_strobe,
	input  ines_pkg::ines_byte_t    in_data,
	output logic                    in_wait,
	input  logic                    invert_mirroring,
	output logic                    mem_write,
	output loader_pkg::mem_addr_t   mem_addr,
	output ines_pkg::ines_byte_t    mem_data,
	output logic                    busy,
	output logic                    done,
	output logic                    error,
	output ines_pkg::mapper_flags_t flags
);
	import ines_pkg::*;
	import loader_pkg::*;

	// Parser to sequencer
	logic        load_start;
	page_count_t prg_pages;
	page_count_t chr_pages;
	logic        pay_strobe;
	ines_byte_t  pay_data;

	// Sequencer to buffer
	logic       wr_req;
	mem_addr_t  wr_addr;
	ines_byte_t wr_data;
	logic       wr_done;

	ines_header_parser parser_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.in_strobe        (in_strobe),
		.in_data          (in_data),
		.invert_mirroring (invert_mirroring),
		.load_start       (load_start),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.pay_strobe       (pay_strobe),
		.pay_data         (pay_data),
		.error            (error),
		.flags            (flags)
	);

	rom_address_sequencer sequencer_inst (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.load_start (load_start),
		.prg_pages  (prg_pages),
		.chr_pages  (chr_pages),
		.pay_strobe (pay_strobe),
		.pay_data   (pay_data),
		.wr_done    (wr_done),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.busy       (busy),
		.done       (done)
	);

	mem_write_buffer buffer_inst (
		.clk       (clk),
		.reset_nes (reset_nes),
		.wr_req    (wr_req),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_done   (wr_done),
		.in_wait   (in_wait),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data)
	);

endmodule

// ==== tests/loader_tb_tasks.svh ====
// Loader testbench compare tasks
// Typed checks for the flag word, memory writes and status values,
// and the summary line printed as each test finishes

`ifndef LOADER_TB_TASKS_SVH
`define LOADER_TB_TASKS_SVH

task automatic check_flags(input mapper_flags_t got, input mapper_flags_t exp);
	if (got !== exp) begin
		$display("** Error at %0t ns: flags %h, expected %h", $time, got, exp);
		$display("   mapper %h/%h nes20 %h/%h mirror %b/%b chr_ram %b/%b", got.mapper,
			exp.mapper, got.nes20_mapper, exp.nes20_mapper, got.mirroring, exp.mirroring,
			got.chr_ram, exp.chr_ram);
		error_count++;
	end
endtask

task automatic check_write(input mem_addr_t got_addr, input mem_addr_t exp_addr,
	input ines_byte_t got_data, input ines_byte_t exp_data);
	if (got_addr !== exp_addr || got_data !== exp_data) begin
		$display("** Error at %0t ns: write %h <= %h, expected %h <= %h", $time,
			got_addr, got_data, exp_addr, exp_data);
		error_count++;
	end
endtask

// Single status bits and counts
task automatic check_status(input string what, input logic [31:0] got,
	input logic [31:0] exp);
	if (got !== exp) begin
		$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		error_count++;
	end
endtask

task automatic print_test_result(input int num, input int errs);
	tests_run++;
	if (errs == 0) begin
		tests_passed++;
		$display("Test %0d passed, %0d writes", num, writes_seen);
	end else begin
		$display("Test %0d failed with %0d errors", num, errs);
	end
endtask

`endif

// ==== tests/tb_game_loader.sv ====
`timescale 1ns/1ns
`include "loader_settings.svh"

// Cartridge image loader testbench
// Replays header patterns from a data file, streams seeded random payload
// and checks every memory write, the status outputs and the mapper flags

module tb_game_loader;
	import ines_pkg::*;
	import loader_pkg::*;

	localparam int LINE_WORDS = 20; // Header, invert, seed offset, flags, error
	localparam int MAX_TESTS  = 32;
	localparam int SKEW       = 10;

	logic          clk = 1'b0;
	logic          reset_nes;
	logic          in_strobe;
	ines_byte_t    in_data;
	logic          in_wait;
	logic          invert_mirroring;
	logic          mem_write;
	mem_addr_t     mem_addr;
	ines_byte_t    mem_data;
	logic          busy;
	logic          done;
	logic          error;
	mapper_flags_t flags;

	logic [31:0] patterns [LINE_WORDS*MAX_TESTS];
	int          error_count;
	int          tests_run;
	int          tests_passed;
	time         watchdog_limit;
	integer      drive_seed;
	integer      drive_rnd;

	// Reference model of the running test
	int        prg_bytes;
	int        exp_writes;
	int        writes_seen;
	integer    model_seed;
	integer    model_rnd;
	mem_addr_t exp_addr;
	logic      done_prev;

	`include "loader_tb_tasks.svh"

	game_loader game_loader_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.in_strobe        (in_strobe),
		.in_data          (in_data),
		.in_wait          (in_wait),
		.invert_mirroring (invert_mirroring),
		.mem_write        (mem_write),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.flags            (flags)
	);

	always #50 clk = ~clk;

	// Bytes the loader must write for pattern line t
	function automatic int image_bytes(input int t);
		if (patterns[t*LINE_WORDS + 19][0])
			return 0;
		return (int'(patterns[t*LINE_WORDS + 4][7:0]) << `LOADER_PRG_PAGE_SHIFT)
			+ (int'(patterns[t*LINE_WORDS + 5][7:0]) << `LOADER_CHR_PAGE_SHIFT);
	endfunction

	// A few bytes past the image end, they must be dropped
	function automatic int stream_bytes(input int t);
		return patterns[t*LINE_WORDS + 19][0] ? 32 : image_bytes(t) + 8;
	endfunction

	task automatic apply_reset();
		reset_nes = 1'b1;
		repeat (2) @(posedge clk);
		#SKEW;
		reset_nes = 1'b0;
	endtask

	task automatic send_byte(input ines_byte_t value, input logic exp_wait);
		in_strobe = 1'b1;
		in_data   = value;
		@(posedge clk);
		#SKEW;
		in_strobe = 1'b0;
		repeat (2) @(posedge clk); // Parser and sequencer stages
		#SKEW;
		check_status("in_wait", in_wait, exp_wait); // High only for a held write
		while (in_wait) begin
			@(posedge clk);
			#SKEW;
		end
	endtask

	task automatic run_test(input int t);
		int   base;
		int   i;
		int   errors_before;
		logic exp_err;
		base             = t * LINE_WORDS;
		errors_before    = error_count;
		exp_err          = patterns[base + 19][0];
		prg_bytes        = int'(patterns[base + 4][7:0]) << `LOADER_PRG_PAGE_SHIFT;
		exp_writes       = image_bytes(t);
		writes_seen      = 0;
		drive_seed       = 32'had5 + patterns[base + 17];
		model_seed       = drive_seed;
		invert_mirroring = patterns[base + 16][0];
		apply_reset();
		check_status("busy after reset", busy, 0);
		check_status("done after reset", done, 0);
		check_status("error after reset", error, 0);
		check_status("mem_write after reset", mem_write, 0);
		check_status("in_wait after reset", in_wait, 0);
		for (i = 0; i < `LOADER_HEADER_BYTES; i++)
			send_byte(patterns[base + i][7:0], 1'b0);
		check_status("error after header", error, exp_err);
		check_status("busy after header", busy, !exp_err);
		check_status("done after header", done, exp_err);
		for (i = 0; i < stream_bytes(t); i++) begin
			drive_rnd = $random(drive_seed);
			send_byte(drive_rnd[7:0], i < exp_writes);
		end
		while (!done) begin
			@(posedge clk);
			#SKEW;
		end
		check_status("error at done", error, exp_err);
		check_status("busy at done", busy, 0);
		check_status("write count", writes_seen, exp_writes);
		if (!exp_err)
			check_flags(flags, mapper_flags_t'(patterns[base + 18]));
		print_test_result(t + 1, error_count - errors_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Write checker, sampled mid cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (mem_write) begin
			if (writes_seen < exp_writes) begin
				exp_addr = (writes_seen < prg_bytes)
					? mem_addr_t'(`LOADER_PRG_BASE + writes_seen)
					: mem_addr_t'(`LOADER_CHR_BASE + (writes_seen - prg_bytes));
				model_rnd = $random(model_seed);
				check_write(mem_addr, exp_addr, mem_data, model_rnd[7:0]);
			end else begin
				$display("Memory write to %h beyond the image end at %0t ns", mem_addr, $time);
				error_count++;
			end
			writes_seen++;
		end
		if (done && !done_prev && writes_seen != exp_writes) begin
			$display("done rose after %0d of %0d writes at %0t ns", writes_seen, exp_writes,
				$time);
			error_count++;
		end
		done_prev = done;
	end

	initial begin
		wait (watchdog_limit != 0);
		#(watchdog_limit);
		$display("Watchdog expired at %0t ns with tests still running", $time);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int  t;
		int  n_tests;
		time budget;
		reset_nes        = 1'b1;
		in_strobe        = 1'b0;
		in_data          = '0;
		invert_mirroring = 1'b0;
		error_count      = 0;
		tests_run        = 0;
		tests_passed     = 0;
		prg_bytes        = 0;
		exp_writes       = 0;
		writes_seen      = 0;
		done_prev        = 1'b0;
		for (t = 0; t < LINE_WORDS*MAX_TESTS; t++)
			patterns[t] = {16'hdead, t[15:0]}; // Above 0xFF marks an empty line
		$readmemh("tests/loader_patterns.txt", patterns);
		n_tests = 0;
		while (n_tests < MAX_TESTS && patterns[n_tests*LINE_WORDS] <= 32'hff)
			n_tests++;
		budget = 0;
		for (t = 0; t < n_tests; t++)
			budget = budget + time'(stream_bytes(t)) * `LOADER_SLOT_PERIOD * 200;
		watchdog_limit = budget + n_tests * 20000 + 10000;
		@(posedge clk);
		#SKEW;
		for (t = 0; t < n_tests; t++)
			run_test(t);
		if (n_tests == 0)
			$display("No test lines found in tests/loader_patterns.txt");
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
			tests_passed, tests_run - tests_passed, error_count);
		if (error_count == 0 && n_tests > 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+common
+incdir+tests
common/ines_pkg.sv
common/loader_pkg.sv
design/mem_write_buffer.sv
game_loader/ines_header_parser.sv
game_loader/rom_address_sequencer.sv
game_loader/game_loader.sv
tests/tb_game_loader.sv

// ==== tests/loader_patterns.txt ====
// Columns: header bytes 0 to 15, invert_mirroring, seed offset, expected flags, expected error
// Payload seed is 32'had5 plus the seed offset, which is the test's line number
// 1: iNES 1.0, one PRG and one CHR page, vertical mirroring
4E 45 53 1A 01 01 01 00 00 00 00 00 00 00 00 00  0 1 00004000 0
// 2: NES 2.0 with battery, mapper 0x41, extended byte 0x25
4E 45 53 1A 01 01 12 48 25 00 07 00 00 00 00 00  0 2 024A0041 0
// 3: Dirty iNES 1.0 with junk in bytes 11 to 15, two PRG pages, CHR-RAM
4E 45 53 1A 02 00 40 30 69 00 00 44 75 64 65 21  0 3 00008104 0
// 4: Four-screen, CHR-RAM, mirroring inverted
4E 45 53 1A 01 00 08 00 00 00 00 00 00 00 00 00  1 4 0001C000 0
// 5: Bad signature
4E 45 53 00 01 01 00 00 00 00 00 00 00 00 00 00  0 5 00000000 1
// 6: Trainer present
4E 45 53 1A 01 01 04 00 00 00 00 00 00 00 00 00  0 6 00000000 1
// 7: Two PRG pages, one CHR page, byte 9 bit 0 set but still clean
4E 45 53 1A 02 01 21 10 00 01 00 00 00 00 00 00  1 7 00000112 0
